// File: design/sdram_check_pkg.sv
/*
 * Shared definitions for the SDRAM bring-up self-test
 *   - SDRAM command encodings {cs_n, ras_n, cas_n, we_n}
 *   - Bus width typedefs and sequencer timing counts
 *   - State enums for the init and test state machines
 *   - Test word generator used by the sequencer and the checker
 */
`default_nettype none

package sdram_check_pkg;

    // ============================================================
    // Bus and counter widths
    // ============================================================

    // Command word, all four strobes active low
    typedef logic [3:0]  sdram_cmd_t;
    typedef logic [12:0] sdram_addr_t;
    typedef logic [1:0]  sdram_ba_t;
    typedef logic [15:0] sdram_word_t;
    typedef logic [2:0]  test_row_t;
    typedef logic [15:0] delay_t;

    // ============================================================
    // Command encodings
    // ============================================================

    localparam sdram_cmd_t CMD_NOP       = 4'b0111;
    localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
    localparam sdram_cmd_t CMD_READ      = 4'b0101;
    localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
    localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
    localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
    localparam sdram_cmd_t CMD_LOAD_MODE = 4'b0000;

    // ============================================================
    // Timing counts, in clock cycles
    // ============================================================

    // 200 us at 25 MHz
    localparam delay_t INIT_WAIT_CYCLES = 16'd5000;
    localparam delay_t T_RP_CYCLES      = 16'd2;
    localparam delay_t T_RFC_CYCLES     = 16'd8;
    localparam delay_t T_MRD_CYCLES     = 16'd2;
    localparam delay_t T_RCD_CYCLES     = 16'd2;
    // Write recovery and the auto-precharge that follows it
    localparam delay_t T_WR_RP_CYCLES   = 16'd3;
    // CAS latency 2, plus one cycle for the input sample register
    localparam delay_t READ_WAIT_CYCLES = 16'd3;

    localparam int TEST_ROWS = 8;

    // A10 high selects all banks on precharge, auto-precharge on column access
    localparam sdram_addr_t A10_PRECHARGE_ALL = 13'b0_0100_0000_0000;
    // Burst length 1, sequential, CAS latency 2, standard operation
    localparam sdram_addr_t MODE_REG_VALUE    = 13'b000_0_00_010_0_000;

    // ============================================================
    // State machines
    // ============================================================

    typedef enum logic [2:0] {
        INIT_POWER_UP,
        INIT_PRECHARGE,
        INIT_REFRESH_1,
        INIT_REFRESH_2,
        INIT_LOAD_MODE,
        INIT_MODE_WAIT,
        INIT_FINISHED
    } init_state_t;

    typedef enum logic [2:0] {
        TEST_WAIT_INIT,
        TEST_WR_ACT,
        TEST_WR_CMD,
        TEST_WR_RECOVER,
        TEST_RD_ACT,
        TEST_RD_CMD,
        TEST_RD_WAIT,
        TEST_DONE
    } test_state_t;

    // Row number, 10101, row number, 01010 from the top bit down
    function automatic sdram_word_t test_word(input test_row_t row);
        return {row, 5'b10101, row, 5'b01010};
    endfunction

endpackage

`default_nettype wire

// File: design/sdram_check_top.sv
/*
 * SDRAM bring-up self-test top level
 *   - Init sequencer, then test sequencer, then read checker
 *   - DQ bus as separate out, output enable and in ports
 */
`default_nettype none

module sdram_check_top
    import sdram_check_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sdram_word_t dq_in,
    output logic        sdram_cke,
    output sdram_cmd_t  sdram_cmd,
    output sdram_addr_t sdram_addr,
    output sdram_ba_t   sdram_ba,
    output sdram_word_t dq_out,
    output logic        dq_oe,
    output logic        test_pass,
    output logic        test_fail
);

    // ============================================================
    // Inter-stage wires
    // ============================================================

    // Init stage to test sequencer
    sdram_cmd_t  init_cmd;
    sdram_addr_t init_addr;
    sdram_ba_t   init_ba;
    logic        init_cke;
    logic        init_done;

    // Test sequencer to read checker
    logic        check_strobe;
    test_row_t   check_row;
    logic        check_last;

    sdram_init_seq u_init_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_cmd  (init_cmd),
        .init_addr (init_addr),
        .init_ba   (init_ba),
        .init_cke  (init_cke),
        .init_done (init_done)
    );

    sdram_pattern_seq u_pattern_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_cmd     (init_cmd),
        .init_addr    (init_addr),
        .init_ba      (init_ba),
        .init_cke     (init_cke),
        .init_done    (init_done),
        .sdram_cke    (sdram_cke),
        .sdram_cmd    (sdram_cmd),
        .sdram_addr   (sdram_addr),
        .sdram_ba     (sdram_ba),
        .dq_out       (dq_out),
        .dq_oe        (dq_oe),
        .check_strobe (check_strobe),
        .check_row    (check_row),
        .check_last   (check_last)
    );

    sdram_read_check u_read_check (
        .clk          (clk),
        .rst_n        (rst_n),
        .dq_in        (dq_in),
        .check_strobe (check_strobe),
        .check_row    (check_row),
        .check_last   (check_last),
        .test_pass    (test_pass),
        .test_fail    (test_fail)
    );

endmodule

`default_nettype wire

// File: design/sdram_init_seq.sv
/*
 * SDRAM power-up and initialisation sequencer
 *   - Power-up wait with clock enable high
 *   - Precharge all banks, two auto-refreshes, load mode register
 *   - Registered command, address and bank outputs
 *   - init_done level once the mode-load wait has expired
 */
`default_nettype none

module sdram_init_seq
    import sdram_check_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output sdram_cmd_t  init_cmd,
    output sdram_addr_t init_addr,
    output sdram_ba_t   init_ba,
    output logic        init_cke,
    output logic        init_done
);

    init_state_t state;
    // Counts down the wait that follows each step
    delay_t      delay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= INIT_POWER_UP;
            delay     <= INIT_WAIT_CYCLES;
            init_cmd  <= CMD_NOP;
            init_addr <= '0;
            init_ba   <= '0;
            init_cke  <= 1'b0;
            init_done <= 1'b0;
        end else begin
            // Commands last a single cycle
            init_cmd <= CMD_NOP;

            case (state)
                // ============================================================
                // Power-up wait
                // ============================================================
                INIT_POWER_UP: begin
                    // Clock enable goes high on the first cycle out of reset
                    init_cke <= 1'b1;
                    if (delay == '0) begin
                        state <= INIT_PRECHARGE;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                // ============================================================
                // Command steps
                // ============================================================
                INIT_PRECHARGE: begin
                    init_cmd  <= CMD_PRECHARGE;
                    init_addr <= A10_PRECHARGE_ALL;
                    delay     <= T_RP_CYCLES;
                    state     <= INIT_REFRESH_1;
                end

                INIT_REFRESH_1: begin
                    // First refresh once tRP has passed
                    if (delay == '0) begin
                        init_cmd <= CMD_REFRESH;
                        delay    <= T_RFC_CYCLES;
                        state    <= INIT_REFRESH_2;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                INIT_REFRESH_2: begin
                    // Second refresh after tRFC
                    if (delay == '0) begin
                        init_cmd <= CMD_REFRESH;
                        delay    <= T_RFC_CYCLES;
                        state    <= INIT_LOAD_MODE;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                INIT_LOAD_MODE: begin
                    if (delay == '0) begin
                        init_cmd  <= CMD_LOAD_MODE;
                        init_ba   <= '0;
                        init_addr <= MODE_REG_VALUE;
                        delay     <= T_MRD_CYCLES;
                        state     <= INIT_MODE_WAIT;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                INIT_MODE_WAIT: begin
                    // Device is usable once tMRD has expired
                    if (delay == '0) begin
                        init_done <= 1'b1;
                        state     <= INIT_FINISHED;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                // Hold here, init_done stays high until reset
                INIT_FINISHED: begin
                    state <= INIT_FINISHED;
                end

                default: begin
                    state <= INIT_POWER_UP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/sdram_pattern_seq.sv
/*
 * SDRAM write and read test sequencer
 *   - Owns the registered SDRAM command, address, bank and DQ outputs
 *   - Forwards the init stage to the pins until init_done
 *   - Writes the test word to column 0 of rows 0 to 7 of bank 0
 *   - Reads the rows back and strobes the read checker per row
 */
`default_nettype none

module sdram_pattern_seq
    import sdram_check_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sdram_cmd_t  init_cmd,
    input  sdram_addr_t init_addr,
    input  sdram_ba_t   init_ba,
    input  logic        init_cke,
    input  logic        init_done,
    output logic        sdram_cke,
    output sdram_cmd_t  sdram_cmd,
    output sdram_addr_t sdram_addr,
    output sdram_ba_t   sdram_ba,
    output sdram_word_t dq_out,
    output logic        dq_oe,
    output logic        check_strobe,
    output test_row_t   check_row,
    output logic        check_last
);

    test_state_t state;
    delay_t      delay;
    // Row under test, shared by the write and read phases
    test_row_t   row;
    logic        last_row;

    assign last_row = (row == test_row_t'(TEST_ROWS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= TEST_WAIT_INIT;
            delay        <= '0;
            row          <= '0;
            sdram_cke    <= 1'b0;
            sdram_cmd    <= CMD_NOP;
            sdram_addr   <= '0;
            sdram_ba     <= '0;
            dq_out       <= '0;
            dq_oe        <= 1'b0;
            check_strobe <= 1'b0;
            check_row    <= '0;
            check_last   <= 1'b0;
        end else begin
            // NOP, bus released and no strobe unless a state says otherwise
            sdram_cmd    <= CMD_NOP;
            dq_oe        <= 1'b0;
            check_strobe <= 1'b0;

            case (state)
                // ============================================================
                // Init stage drives the pins
                // ============================================================
                TEST_WAIT_INIT: begin
                    if (!init_done) begin
                        sdram_cke  <= init_cke;
                        sdram_cmd  <= init_cmd;
                        sdram_addr <= init_addr;
                        sdram_ba   <= init_ba;
                    end else begin
                        row   <= '0;
                        state <= TEST_WR_ACT;
                    end
                end

                // ============================================================
                // Write phase
                // ============================================================
                TEST_WR_ACT: begin
                    // Open the row in bank 0
                    sdram_cmd  <= CMD_ACTIVE;
                    sdram_ba   <= '0;
                    sdram_addr <= sdram_addr_t'(row);
                    delay      <= T_RCD_CYCLES;
                    state      <= TEST_WR_CMD;
                end

                TEST_WR_CMD: begin
                    if (delay == '0) begin
                        // Column 0 with auto-precharge, data driven for this cycle only
                        sdram_cmd  <= CMD_WRITE;
                        sdram_addr <= A10_PRECHARGE_ALL;
                        dq_out     <= test_word(row);
                        dq_oe      <= 1'b1;
                        // Expiry cycle itself counts toward the recovery time
                        delay      <= T_WR_RP_CYCLES - 16'd1;
                        state      <= TEST_WR_RECOVER;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                TEST_WR_RECOVER: begin
                    if (delay == '0) begin
                        if (last_row) begin
                            // All rows written, restart from row 0 for reads
                            row   <= '0;
                            state <= TEST_RD_ACT;
                        end else begin
                            row   <= row + 3'd1;
                            state <= TEST_WR_ACT;
                        end
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                // ============================================================
                // Read phase
                // ============================================================
                TEST_RD_ACT: begin
                    sdram_cmd  <= CMD_ACTIVE;
                    sdram_ba   <= '0;
                    sdram_addr <= sdram_addr_t'(row);
                    delay      <= T_RCD_CYCLES;
                    state      <= TEST_RD_CMD;
                end

                TEST_RD_CMD: begin
                    if (delay == '0) begin
                        sdram_cmd  <= CMD_READ;
                        sdram_addr <= A10_PRECHARGE_ALL;
                        delay      <= READ_WAIT_CYCLES;
                        state      <= TEST_RD_WAIT;
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                TEST_RD_WAIT: begin
                    // Data has reached the checker's sample register on expiry
                    if (delay == '0) begin
                        check_strobe <= 1'b1;
                        check_row    <= row;
                        check_last   <= last_row;
                        if (last_row) begin
                            state <= TEST_DONE;
                        end else begin
                            row   <= row + 3'd1;
                            state <= TEST_RD_ACT;
                        end
                    end else begin
                        delay <= delay - 16'd1;
                    end
                end

                // Test complete, pins stay at NOP until reset
                TEST_DONE: begin
                    state <= TEST_DONE;
                end

                default: begin
                    state <= TEST_WAIT_INIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/sdram_read_check.sv
/*
 * SDRAM read-back checker
 *   - Samples the DQ input bus on every cycle
 *   - Compares the sample with the expected word at each check strobe
 *   - Sticky pass and fail flags
 */
`default_nettype none

module sdram_read_check
    import sdram_check_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sdram_word_t dq_in,
    input  logic        check_strobe,
    input  test_row_t   check_row,
    input  logic        check_last,
    output logic        test_pass,
    output logic        test_fail
);

    sdram_word_t dq_sample;
    sdram_word_t expected;
    logic        word_error;

    // ============================================================
    // Input sample register
    // ============================================================

    // Captures the pin data one cycle before the strobe arrives
    always_ff @(posedge clk) begin
        dq_sample <= dq_in;
    end

    // ============================================================
    // Compare
    // ============================================================

    assign expected   = test_word(check_row);
    assign word_error = (dq_sample != expected);

    // ============================================================
    // Result latches
    // ============================================================

    // test_fail doubles as the mismatch latch, so a later good row
    // cannot turn a failed run into a pass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            test_pass <= 1'b0;
            test_fail <= 1'b0;
        end else if (check_strobe) begin
            if (word_error && !test_pass) begin
                test_fail <= 1'b1;
            end else if (check_last && !word_error && !test_fail) begin
                // Last row matched and no earlier row failed
                test_pass <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: list.f
design/sdram_check_pkg.sv
design/sdram_init_seq.sv
design/sdram_pattern_seq.sv
design/sdram_read_check.sv
design/sdram_check_top.sv
sim/sdram_model.sv
sim/sdram_check_asserts.sv
sim/tb_sdram_check.sv

// File: run.sh
#!/usr/bin/env bash
# Build the SDRAM self-test simulation with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_sdram_check -Mdir obj_dir -o sim_sdram_check -f list.f \
    && ./obj_dir/sim_sdram_check 2>&1 | tee sim.log \
    || { echo "Build or simulation run did not complete"; exit 1; }

grep -qx "=== PASS ===" sim.log \
    && echo "Log check: simulation passed" \
    || { echo "Log check: simulation failed"; exit 1; }

// File: sim/sdram_check_asserts.sv
/*
 * Concurrent assertions for the SDRAM self-test top level
 *   - Pass and fail flags exclusive and sticky
 *   - Data bus driven only with a WRITE command
 */
`default_nettype none

module sdram_check_asserts
    import sdram_check_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input sdram_cmd_t sdram_cmd,
    input logic       dq_oe,
    input logic       test_pass,
    input logic       test_fail
);
    timeunit 1ns;
    timeprecision 1ns;

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(test_pass && test_fail))
        else $error("Pass and fail flags high together");

    // Output enable and command come from the same register stage
    oe_only_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        dq_oe |-> (sdram_cmd == CMD_WRITE))
        else $error("dq_oe high without a WRITE command");

    pass_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        test_pass |=> test_pass)
        else $error("test_pass dropped before reset");

    fail_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        test_fail |=> test_fail)
        else $error("test_fail dropped before reset");

endmodule

`default_nettype wire

// File: sim/sdram_model.sv
/*
 * Behavioural SDRAM for the self-test testbench
 *   - One word per row of bank 0, column 0 only
 *   - CAS latency 2, data held until the next command
 *   - Optional fault mask on the word read from one row
 */
`default_nettype none

module sdram_model
    import sdram_check_pkg::*;
(
    input  logic        clk,
    input  sdram_cmd_t  sdram_cmd,
    input  sdram_addr_t sdram_addr,
    input  sdram_word_t dq_out,
    input  logic        dq_oe,
    input  logic        fault_en,
    input  test_row_t   fault_row,
    input  sdram_word_t fault_mask,
    output sdram_word_t dq_in
);
    timeunit 1ns;
    timeprecision 1ns;

    sdram_word_t mem [TEST_ROWS];
    // Row opened by the last ACTIVE
    test_row_t   open_row;
    // READ seen on the previous edge, data goes out on this one
    logic        read_armed;
    sdram_word_t read_word;

    initial begin
        dq_in      = '0;
        open_row   = '0;
        read_armed = 1'b0;
        read_word  = '0;
    end

    always @(posedge clk) begin
        read_armed <= 1'b0;
        // Any command releases the bus, otherwise armed read data appears
        if (sdram_cmd != CMD_NOP) begin
            dq_in <= '0;
        end else if (read_armed) begin
            dq_in <= read_word;
        end

        case (sdram_cmd)
            CMD_ACTIVE: begin
                open_row <= test_row_t'(sdram_addr);
            end
            CMD_WRITE: begin
                if (dq_oe) begin
                    mem[open_row] <= dq_out;
                end
            end
            CMD_READ: begin
                read_armed <= 1'b1;
                // Corrupt the chosen row on its way out
                if (fault_en && open_row == fault_row) begin
                    read_word <= mem[open_row] ^ fault_mask;
                end else begin
                    read_word <= mem[open_row];
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: sim/tb_sdram_check.sv
/*
 * Testbench for the SDRAM bring-up self-test
 *   - Clock, reset and six random trials with optional fault injection
 *   - Expected pin command sequence built from the test rules
 *   - Flag checks, mid-trial resets and a global cycle timeout
 */
`default_nettype none

module tb_sdram_check
    import sdram_check_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int TRIALS         = 6;
    localparam int TRIAL_CYCLES   = 6000;
    localparam int TIMEOUT_CYCLES = TRIALS * TRIAL_CYCLES;
    localparam int RESET_CYCLES   = 10;
    // Four init commands, then ACTIVE plus WRITE and ACTIVE plus READ per row
    localparam int SEQ_LEN        = 4 + 4 * TEST_ROWS;

    logic        clk;
    logic        rst_n;
    sdram_word_t dq_in;
    logic        sdram_cke;
    sdram_cmd_t  sdram_cmd;
    sdram_addr_t sdram_addr;
    sdram_ba_t   sdram_ba;
    sdram_word_t dq_out;
    logic        dq_oe;
    logic        test_pass;
    logic        test_fail;

    // Fault injection controls for the memory model
    logic        fault_en;
    test_row_t   fault_row;
    sdram_word_t fault_mask;

    logic [31:0] rng;
    int          cycles_total = 0;

    // Expected non-NOP commands in pin order
    sdram_cmd_t  exp_cmd [$];
    sdram_addr_t exp_addr [$];
    sdram_word_t exp_data [$];

    sdram_check_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .dq_in      (dq_in),
        .sdram_cke  (sdram_cke),
        .sdram_cmd  (sdram_cmd),
        .sdram_addr (sdram_addr),
        .sdram_ba   (sdram_ba),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .test_pass  (test_pass),
        .test_fail  (test_fail)
    );

    sdram_model u_sdram (
        .clk        (clk),
        .sdram_cmd  (sdram_cmd),
        .sdram_addr (sdram_addr),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .fault_en   (fault_en),
        .fault_row  (fault_row),
        .fault_mask (fault_mask),
        .dq_in      (dq_in)
    );

    bind sdram_check_top sdram_check_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .sdram_cmd (sdram_cmd),
        .dq_oe     (dq_oe),
        .test_pass (test_pass),
        .test_fail (test_fail)
    );

    // ============================================================
    // Clock and timeout
    // ============================================================

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles_total <= cycles_total + 1;
        if (cycles_total >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout: the trials did not finish within the cycle limit");
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL t=%0t %s got 0x%0h expected 0x%0h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic push_command(input sdram_cmd_t cmd, input sdram_addr_t addr,
                                input sdram_word_t data);
        exp_cmd.push_back(cmd);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Init sequence, then one write slot and one read slot per row
    task automatic build_expected();
        push_command(CMD_PRECHARGE, A10_PRECHARGE_ALL, '0);
        push_command(CMD_REFRESH, '0, '0);
        push_command(CMD_REFRESH, '0, '0);
        push_command(CMD_LOAD_MODE, MODE_REG_VALUE, '0);
        for (int r = 0; r < TEST_ROWS; r++) begin
            push_command(CMD_ACTIVE, sdram_addr_t'(r), '0);
            push_command(CMD_WRITE, A10_PRECHARGE_ALL, test_word(test_row_t'(r)));
        end
        for (int r = 0; r < TEST_ROWS; r++) begin
            push_command(CMD_ACTIVE, sdram_addr_t'(r), '0);
            push_command(CMD_READ, A10_PRECHARGE_ALL, '0);
        end
    endtask

    task automatic check_idle();
        check_value("sdram_cke", 32'(sdram_cke), 32'd0);
        check_value("sdram_cmd", 32'(sdram_cmd), 32'(CMD_NOP));
        check_value("dq_oe", 32'(dq_oe), 32'd0);
        check_value("test_pass", 32'(test_pass), 32'd0);
        check_value("test_fail", 32'(test_fail), 32'd0);
    endtask

    // Reset for 10 cycles, outputs idle throughout and one edge past release
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    // Follow the pin commands until the whole sequence is out and a flag is up,
    // or for limit cycles if nonzero
    task automatic watch_sequence(input int limit);
        int   seen;
        int   since_release;
        logic done;
        seen          = 0;
        since_release = 1;
        done          = 1'b0;
        while (!done) begin
            @(negedge clk);
            since_release++;
            if (sdram_cmd != CMD_NOP) begin
                if (seen == SEQ_LEN) begin
                    stop_with_error("Extra command issued after the last read");
                end
                if (seen == 0 && since_release < int'(INIT_WAIT_CYCLES)) begin
                    stop_with_error("First command issued before the power-up wait ended");
                end
                check_value("sdram_cmd", 32'(sdram_cmd), 32'(exp_cmd[seen]));
                check_value("sdram_cke", 32'(sdram_cke), 32'd1);
                check_value("sdram_ba", 32'(sdram_ba), 32'd0);
                // Refresh ignores the address bus
                if (exp_cmd[seen] != CMD_REFRESH) begin
                    check_value("sdram_addr", 32'(sdram_addr), 32'(exp_addr[seen]));
                end
                if (exp_cmd[seen] == CMD_WRITE) begin
                    check_value("dq_oe", 32'(dq_oe), 32'd1);
                    check_value("dq_out", 32'(dq_out), 32'(exp_data[seen]));
                end
                seen++;
            end
            if (limit == 0) begin
                // A mismatch raises the fail flag early, the reads still run to row 7
                done = (seen == SEQ_LEN) && (test_pass || test_fail);
            end else begin
                done = (since_release >= limit);
            end
        end
    endtask

    // Flag matches the fault setting and holds past the last row's strobe
    task automatic check_result();
        repeat (int'(READ_WAIT_CYCLES) + 5) begin
            check_value("test_fail", 32'(test_fail), 32'(fault_en));
            check_value("test_pass", 32'(test_pass), 32'(!fault_en));
            @(negedge clk);
        end
    endtask

    // ============================================================
    // Trials
    // ============================================================

    initial begin
        rst_n      = 1'b0;
        fault_en   = 1'b0;
        fault_row  = '0;
        fault_mask = '0;
        rng        = 32'h214f;
        build_expected();

        for (int t = 0; t < TRIALS; t++) begin
            rng = xorshift32(rng);
            @(posedge clk);
            // First two trials cover both outcomes, the rest are random
            fault_en   <= (t < 2) ? ((t % 2) == 1) : rng[0];
            fault_row  <= rng[4:2];
            fault_mask <= (rng[31:16] == 16'd0) ? 16'h0001 : rng[31:16];
            $display("Trial %0d fault=%0d row=%0d", t, (t < 2) ? (t % 2) : int'(rng[0]),
                     rng[4:2]);
            // Cut the trial short with a second reset
            if (rng[5]) begin
                apply_reset();
                watch_sequence(16 + int'(rng[14:6]));
            end
            apply_reset();
            watch_sequence(0);
            check_result();
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
